// ==== Makefile ====
# Verilator build, run, lint and clean for the madam project.
VERILATOR ?= verilator
TOP ?= madam_tb
FILELIST ?= madam.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the simulation output only.
run: build
	@out="$$($(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/madam_tb.sv ====
// testbench for the madam register block.
// lfsr stimulus, reference models for the msb finder and the matrix rows,
// register, pcsc capture and matrix engine checks with a cycle timeout.
`include "madam_macros.svh"

module madam_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int MAX_CYCLES = 2000;	// several times the length of all tests.
	localparam logic [15:0] ADDR_HI = 16'h0330;	// upper address half that the decode ignores.
	localparam madam_pkg::reg_offset_t RW_REGS [6] = '{`MADAM_MCTL, `MADAM_SLTIME,
		`MADAM_REGCTL0, `MADAM_REGCTL1, `MADAM_REGCTL2, `MADAM_REGCTL3};

	logic clk_25m;
	logic reset_n;
	madam_pkg::cpu_word_t cpu_addr;
	madam_pkg::cpu_word_t cpu_din;
	logic cpu_wr;
	madam_pkg::cpu_word_t cpu_dout;
	logic pcsc;
	madam_pkg::hcount_t hcount;
	madam_pkg::video_flags_t video_flags;
	logic matrix_busy;

	logic [31:0] lfsr_state = 32'hf5361bea;
	int cycle_count = 0;
	madam_pkg::fix16_t mat_model [16];	// matrix words as written in row order.
	madam_pkg::fix16_t vec_model [4];
	madam_pkg::fix16_t rez_exp [4];	// expected cpu visible results.
	madam_pkg::fix16_t rezt_exp [4];	// expected shadow results.
	logic [31:0] rnd;
	int busy_cycles;

	madam madam_inst (
		.clk_25m(clk_25m),
		.reset_n(reset_n),
		.cpu_addr(cpu_addr),
		.cpu_din(cpu_din),
		.cpu_wr(cpu_wr),
		.cpu_dout(cpu_dout),
		.pcsc(pcsc),
		.hcount(hcount),
		.video_flags(video_flags),
		.matrix_busy(matrix_busy)
	);

	always #20 clk_25m = ~clk_25m;	// 40 ns period.

	always @(posedge clk_25m) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// galois lfsr for x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// n random bits in the low end with one lfsr step per bit.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// 20 bit signed value keeps the number within -8.0 to +8.0.
	function automatic madam_pkg::fix16_t rand_fix();
		logic [31:0] b;
		b = rand_bits(20);
		return {{12{b[19]}}, b[19:0]};
	endfunction

	// highest set bit searched from the top and all ones for zero.
	function automatic logic [31:0] ref_msb(input logic [31:0] v);
		for (int i = 31; i >= 0; i--) begin
			if (v[i])
				return 32'(i);
		end
		return 32'hFFFFFFFF;
	endfunction

	// signed 64 bit sum of products over n columns shifted back to 16.16.
	function automatic madam_pkg::fix16_t ref_row(input int r, input int n);
		madam_pkg::mac_acc_t sum;
		sum = '0;
		for (int c = 0; c < n; c++)
			sum = sum + madam_pkg::mac_acc_t'(mat_model[4 * r + c]) *
				madam_pkg::mac_acc_t'(vec_model[c]);
		sum = sum >>> `MATRIX_FRAC_BITS;
		return sum[31:0];	// truncated.
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			$display("Testbench failed");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic write_reg(input madam_pkg::reg_offset_t off, input logic [31:0] data);
		@(negedge clk_25m);
		cpu_addr = {ADDR_HI, off};
		cpu_din = data;
		cpu_wr = 1'b1;	// taken at the next rising edge.
	endtask

	// combinational read data sampled well before the rising edge.
	task automatic read_check(input string name, input madam_pkg::reg_offset_t off,
		input logic [31:0] expected);
		@(negedge clk_25m);
		cpu_addr = {ADDR_HI, off};
		cpu_din = '0;
		cpu_wr = 1'b0;
		#5;
		check(name, expected, cpu_dout);
	endtask

	// counts falling edges with busy high until the engine is idle.
	// the busy bit at 0x07FC is polled alongside.
	task automatic wait_idle(output int cycles);
		cycles = 0;
		@(negedge clk_25m);
		cpu_addr = {ADDR_HI, `MADAM_MATRIX_CMD};
		cpu_din = '0;
		cpu_wr = 1'b0;
		#5;
		while (matrix_busy) begin
			check("busy bit while busy", 32'd1, cpu_dout);
			cycles++;
			@(negedge clk_25m);
			#5;
		end
		check("busy bit idle", 32'd0, cpu_dout);
	endtask

	// every known command publishes the shadow results first.
	task automatic matrix_cmd(input logic [31:0] cmd, input int n);
		write_reg(`MADAM_MATRIX_CMD, cmd);
		for (int i = 0; i < 4; i++)
			rez_exp[i] = rezt_exp[i];
		for (int r = 0; r < n; r++)
			rezt_exp[r] = ref_row(r, n);	// rows beyond n keep their value.
	endtask

	task automatic load_operands();
		for (int i = 0; i < 16; i++) begin
			mat_model[i] = rand_fix();
			write_reg(`MADAM_MATRIX_BASE + 16'(4 * i), mat_model[i]);
		end
		for (int i = 0; i < 4; i++) begin
			vec_model[i] = rand_fix();
			write_reg(`MADAM_VECTOR_BASE + 16'(4 * i), vec_model[i]);
		end
	endtask

	task automatic check_rez(input string tag);
		for (int i = 0; i < 4; i++)
			read_check($sformatf("%s rez%0d", tag, i), `MADAM_REZ_BASE + 16'(4 * i), rez_exp[i]);
	endtask

	// line start bit and seven flags with hcount checked on every cycle.
	task automatic send_flags(input madam_pkg::video_flags_t pattern);
		repeat (2) begin
			@(negedge clk_25m);
			cpu_wr = 1'b0;
			pcsc = 1'b0;	// low gap.
		end
		@(negedge clk_25m);
		pcsc = 1'b1;
		for (int k = 0; k < 7; k++) begin
			@(negedge clk_25m);
			check($sformatf("hcount at flag %0d", k), 32'(k), 32'(hcount));
			pcsc = pattern[k];	// toggles here must not restart the line.
		end
		@(negedge clk_25m);
		check("hcount after capture", 32'd7, 32'(hcount));
		pcsc = 1'b0;
		@(negedge clk_25m);
		check("hcount one cycle later", 32'd8, 32'(hcount));
		check($sformatf("video flags %b", pattern), 32'(pattern), 32'(video_flags));
	endtask

	initial begin
		clk_25m = 1'b0;
		reset_n = 1'b0;
		cpu_addr = '0;
		cpu_din = '0;
		cpu_wr = 1'b0;
		pcsc = 1'b0;
		for (int i = 0; i < 4; i++) begin
			rez_exp[i] = '0;
			rezt_exp[i] = '0;
		end
		repeat (2) @(negedge clk_25m);
		reset_n = 1'b1;

		check("reset video flags", 32'd0, 32'(video_flags));
		check("reset matrix busy", 32'd0, 32'(matrix_busy));
		read_check("reset mctl", `MADAM_MCTL, 32'd0);
		read_check("reset regctl0", `MADAM_REGCTL0, 32'd0);
		read_check("reset rez0", `MADAM_REZ_BASE, 32'd0);

		for (int i = 0; i < 6; i++) begin
			rnd = rand_bits(32);
			write_reg(RW_REGS[i], rnd);
			read_check($sformatf("register %h", RW_REGS[i]), RW_REGS[i], rnd);
		end
		write_reg(`MADAM_MSYSBITS, rand_bits(32));	// read only.
		read_check("msysbits", `MADAM_MSYSBITS, 32'h29);
		read_check("unused 0500", 16'h0500, 32'hBADACCE5);
		read_check("unused 0700", 16'h0700, 32'hBADACCE5);

		write_reg(`MADAM_MSB_CHECK, 32'h84000000);
		read_check("msb 84000000", `MADAM_MSB_CHECK, ref_msb(32'h84000000));
		write_reg(`MADAM_MSB_CHECK, 32'h0);
		read_check("msb zero", `MADAM_MSB_CHECK, ref_msb(32'h0));
		write_reg(`MADAM_MSB_CHECK, 32'h1);
		read_check("msb one", `MADAM_MSB_CHECK, ref_msb(32'h1));
		for (int i = 0; i < 20; i++) begin
			rnd = rand_bits(32) >> rand_bits(5);	// spread the top bit around.
			write_reg(`MADAM_MSB_CHECK, rnd);
			read_check($sformatf("msb %h", rnd), `MADAM_MSB_CHECK, ref_msb(rnd));
		end

		send_flags(7'b1010101);
		for (int i = 0; i < 6; i++) begin
			rnd = rand_bits(7);
			send_flags(rnd[6:0]);
		end

		load_operands();
		matrix_cmd(`MATRIX_CMD_4X4, 4);
		wait_idle(busy_cycles);
		check("4x4 busy cycles", 32'd16, 32'(busy_cycles));
		check_rez("4x4 before nop");
		matrix_cmd(`MATRIX_CMD_NOP, 0);
		check_rez("4x4 after nop");

		load_operands();
		matrix_cmd(`MATRIX_CMD_3X3, 3);
		write_reg(`MADAM_MATRIX_BASE, ~mat_model[0]);	// lands while busy.
		check("busy at matrix write", 32'd1, 32'(matrix_busy));
		wait_idle(busy_cycles);
		check("3x3 busy cycles", 32'd9, 32'(busy_cycles + 1));	// first busy cycle was the write.
		read_check("matrix write during busy", `MADAM_MATRIX_BASE, mat_model[0]);
		check_rez("3x3 before nop");
		matrix_cmd(`MATRIX_CMD_NOP, 0);
		check_rez("3x3 after nop");

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== madam.f ====
+incdir+rtl
rtl/madam_pkg.sv
rtl/pcsc_capture.sv
rtl/madam_regs.sv
rtl/matrix_engine.sv
rtl/madam_read_mux.sv
rtl/madam.sv
bench/madam_tb.sv

// ==== rtl/madam.sv ====
// madam top level around the cpu register bus.
// pcsc capture, general registers, matrix engine and read mux.
`include "madam_macros.svh"

module madam (
	input logic clk_25m,
	input logic reset_n,
	input madam_pkg::cpu_word_t cpu_addr,
	input madam_pkg::cpu_word_t cpu_din,
	input logic cpu_wr,
	output madam_pkg::cpu_word_t cpu_dout,
	input logic pcsc,
	output madam_pkg::hcount_t hcount,
	output madam_pkg::video_flags_t video_flags,
	output logic matrix_busy
);

	madam_pkg::reg_offset_t offset;	// register offset inside the madam space.
	madam_pkg::cpu_word_t mctl;
	madam_pkg::cpu_word_t sltime;
	madam_pkg::cpu_word_t msb_value;
	madam_pkg::cpu_word_t regctl0;
	madam_pkg::cpu_word_t regctl1;
	madam_pkg::cpu_word_t regctl2;
	madam_pkg::cpu_word_t regctl3;
	madam_pkg::cpu_word_t mat_rdata;
	logic mat_sel;

	assign offset = cpu_addr[`MADAM_OFFSET_BITS-1:0];

	// video flags and line timing from the serial pcsc line.
	pcsc_capture pcsc_capture_inst (
		.clk_25m(clk_25m),
		.reset_n(reset_n),
		.pcsc(pcsc),
		.hcount(hcount),
		.video_flags(video_flags)
	);

	madam_regs madam_regs_inst (
		.clk_25m(clk_25m),
		.reset_n(reset_n),
		.offset(offset),
		.cpu_din(cpu_din),
		.cpu_wr(cpu_wr),
		.mctl(mctl),
		.sltime(sltime),
		.msb_value(msb_value),
		.regctl0(regctl0),
		.regctl1(regctl1),
		.regctl2(regctl2),
		.regctl3(regctl3)
	);

	matrix_engine matrix_engine_inst (
		.clk_25m(clk_25m),
		.reset_n(reset_n),
		.offset(offset),
		.cpu_din(cpu_din),
		.cpu_wr(cpu_wr),
		.mat_rdata(mat_rdata),
		.mat_sel(mat_sel),
		.busy(matrix_busy)	// cpu also polls it at 0x07FC.
	);

	// reads are combinational from the offset.
	madam_read_mux madam_read_mux_inst (
		.offset(offset),
		.mctl(mctl),
		.sltime(sltime),
		.msb_value(msb_value),
		.regctl0(regctl0),
		.regctl1(regctl1),
		.regctl2(regctl2),
		.regctl3(regctl3),
		.mat_sel(mat_sel),
		.mat_rdata(mat_rdata),
		.cpu_dout(cpu_dout)
	);

endmodule

// ==== rtl/madam_macros.svh ====
// register offsets, fixed read values and matrix constants for madam.
// matrix command codes and the pcsc capture length.
`ifndef MADAM_MACROS_SVH
`define MADAM_MACROS_SVH

// cpu offset width, the low bits of cpu_addr.
`define MADAM_OFFSET_BITS 16

// fixed read values.
`define MADAM_MSYSBITS_VALUE 32'h29	// 2MB dram, 1MB vram.
`define MADAM_BAD_READ 32'hBADACCE5	// returned for unmapped offsets.

// general registers.
`define MADAM_MSYSBITS 16'h0004	// memory config, read only.
`define MADAM_MCTL 16'h0008	// dma channel enables.
`define MADAM_SLTIME 16'h000C	// slot timing.
`define MADAM_MSB_CHECK 16'h002C	// msb finder.

// sprite engine region registers.
`define MADAM_REGCTL0 16'h0130	// read and write modulo.
`define MADAM_REGCTL1 16'h0134	// x and y clip.
`define MADAM_REGCTL2 16'h0138	// read base address.
`define MADAM_REGCTL3 16'h013C	// write base address.

// matrix engine space.
`define MADAM_MATRIX_BASE 16'h0600	// 4x4 matrix, 16 words row by row.
`define MADAM_VECTOR_BASE 16'h0640	// 4 vector words.
`define MADAM_REZ_BASE 16'h0660	// 4 result words.
`define MADAM_MATRIX_CMD 16'h07FC	// command on write, busy on read.

// fraction bits of the 16.16 format.
`define MATRIX_FRAC_BITS 16

// matrix command codes.
`define MATRIX_CMD_NOP 32'd0	// copy shadow results only.
`define MATRIX_CMD_4X4 32'd1	// 4x4 matrix times vector.
`define MATRIX_CMD_3X3 32'd2	// 3x3 matrix times vector.

// last flag index of a pcsc capture.
`define MADAM_PCSC_LAST_BIT 3'd7

`endif

// ==== rtl/madam_pkg.sv ====
// shared types for the madam register block.
// cpu words, register offsets, 16.16 fixed point, video timing and the matrix fsm state.
package madam_pkg;

	// cpu side.
	typedef logic [31:0] cpu_word_t;	// one cpu data word.
	typedef logic [15:0] reg_offset_t;	// low half of the cpu address.

	// matrix engine arithmetic.
	typedef logic signed [31:0] fix16_t;	// signed 16.16 value.
	typedef logic signed [63:0] mac_acc_t;	// full product and running sum.

	// video line timing.
	typedef logic [11:0] hcount_t;	// pixel counter within a line.

	// per-line flags from pcsc, bit 0 is the first flag after the ignored bit.
	// order is VZ, V#, F#, FC, VR, VD, VL.
	typedef logic [6:0] video_flags_t;

	// matrix engine sequencer.
	typedef enum logic {
		MAT_IDLE,	// waiting for a command.
		MAT_MAC		// one multiply-accumulate per cycle.
	} mat_state_t;

endpackage

// ==== rtl/madam_read_mux.sv ====
// cpu read data select for madam.
// msb finder priority encoder and the fixed read values.
`include "madam_macros.svh"

module madam_read_mux (
	input madam_pkg::reg_offset_t offset,
	input madam_pkg::cpu_word_t mctl,
	input madam_pkg::cpu_word_t sltime,
	input madam_pkg::cpu_word_t msb_value,
	input madam_pkg::cpu_word_t regctl0,
	input madam_pkg::cpu_word_t regctl1,
	input madam_pkg::cpu_word_t regctl2,
	input madam_pkg::cpu_word_t regctl3,
	input logic mat_sel,
	input madam_pkg::cpu_word_t mat_rdata,
	output madam_pkg::cpu_word_t cpu_dout
);

	madam_pkg::cpu_word_t msb_index;

	// index of the highest set bit, all ones for zero.
	// 0x84000000 gives 31.
	always_comb begin
		msb_index = '1;
		for (int i = 0; i < 32; i++) begin
			if (msb_value[i])
				msb_index = madam_pkg::cpu_word_t'(i);	// later bits win.
		end
	end

	always_comb begin
		case (offset)
			`MADAM_MSYSBITS: cpu_dout = `MADAM_MSYSBITS_VALUE;
			`MADAM_MCTL: cpu_dout = mctl;
			`MADAM_SLTIME: cpu_dout = sltime;
			`MADAM_MSB_CHECK: cpu_dout = msb_index;	// not the stored value.
			`MADAM_REGCTL0: cpu_dout = regctl0;
			`MADAM_REGCTL1: cpu_dout = regctl1;
			`MADAM_REGCTL2: cpu_dout = regctl2;
			`MADAM_REGCTL3: cpu_dout = regctl3;
			default: begin
				// matrix space, else the bad access marker.
				if (mat_sel)
					cpu_dout = mat_rdata;
				else
					cpu_dout = `MADAM_BAD_READ;
			end
		endcase
	end

endmodule

// ==== rtl/madam_regs.sv ====
// cpu writable madam registers and their write decode.
// memory control, slot timing, msb finder input and the sprite region registers.
`include "madam_macros.svh"

module madam_regs (
	input logic clk_25m,
	input logic reset_n,
	input madam_pkg::reg_offset_t offset,
	input madam_pkg::cpu_word_t cpu_din,
	input logic cpu_wr,
	output madam_pkg::cpu_word_t mctl,
	output madam_pkg::cpu_word_t sltime,
	output madam_pkg::cpu_word_t msb_value,
	output madam_pkg::cpu_word_t regctl0,
	output madam_pkg::cpu_word_t regctl1,
	output madam_pkg::cpu_word_t regctl2,
	output madam_pkg::cpu_word_t regctl3
);

	// mctl holds the dma channel enables.
	// bit 16 enables the player bus, bit 20 the sprite engine.

	// sltime is only stored here.
	// the boot code writes it once during init.

	// msb_value feeds the priority encoder in the read mux.

	// regctl0 packs the read and write modulo of the sprite engine.
	// regctl1 holds the x clip in bits 10:0 and the y clip in bits 26:16.
	// regctl2 and regctl3 are the vram base addresses of the
	// source and destination frame buffers.

	always_ff @(posedge clk_25m) begin
		if (!reset_n) begin
			mctl <= '0;
			sltime <= '0;
			msb_value <= '0;
			regctl0 <= '0;
			regctl1 <= '0;
			regctl2 <= '0;
			regctl3 <= '0;
		end else if (cpu_wr) begin
			case (offset)
				`MADAM_MSYSBITS: begin
					// memory config is fixed.
				end
				`MADAM_MCTL: begin
					mctl <= cpu_din;	// dma enables.
				end
				`MADAM_SLTIME: begin
					sltime <= cpu_din;
				end
				`MADAM_MSB_CHECK: begin
					msb_value <= cpu_din;	// read back as a bit index.
				end
				`MADAM_REGCTL0: begin
					regctl0 <= cpu_din;	// modulo.
				end
				`MADAM_REGCTL1: begin
					regctl1 <= cpu_din;	// clip.
				end
				`MADAM_REGCTL2: begin
					regctl2 <= cpu_din;	// read base.
				end
				`MADAM_REGCTL3: begin
					regctl3 <= cpu_din;	// write base.
				end
				default: begin
					// other offsets belong to the matrix engine or are unmapped.
				end
			endcase
		end
	end

endmodule

// ==== rtl/matrix_engine.sv ====
// matrix engine, 4x4 or 3x3 matrix of 16.16 values times a vector.
// matrix, vector and double buffered result registers,
// and the sequential multiply-accumulate fsm.
`include "madam_macros.svh"

module matrix_engine (
	input logic clk_25m,
	input logic reset_n,
	input madam_pkg::reg_offset_t offset,
	input madam_pkg::cpu_word_t cpu_din,
	input logic cpu_wr,
	output madam_pkg::cpu_word_t mat_rdata,
	output logic mat_sel,
	output logic busy
);

	madam_pkg::fix16_t mat_q [0:15];	// row r, column c at index 4r+c.
	madam_pkg::fix16_t vec_q [0:3];
	madam_pkg::fix16_t rez_q [0:3];	// cpu visible results.
	madam_pkg::fix16_t rezt_q [0:3];	// shadow results of the last command.

	madam_pkg::mat_state_t state;
	logic [1:0] row;
	logic [1:0] col;
	logic [1:0] mat_last;	// 3 for 4x4, 2 for 3x3, same for rows and columns.
	madam_pkg::mac_acc_t acc;

	madam_pkg::mac_acc_t product;
	madam_pkg::mac_acc_t mac_sum;
	madam_pkg::mac_acc_t row_shift;

	logic sel_mat;
	logic sel_vec;
	logic sel_rez;
	logic sel_cmd;
	logic cmd_known;

	// word aligned decode, vector and rez are four words each.
	assign sel_mat = (offset >= `MADAM_MATRIX_BASE) && (offset < `MADAM_VECTOR_BASE) &&
		(offset[1:0] == 2'b00);
	assign sel_vec = (offset >= `MADAM_VECTOR_BASE) &&
		(offset < (`MADAM_VECTOR_BASE + 16'h0010)) && (offset[1:0] == 2'b00);
	assign sel_rez = (offset >= `MADAM_REZ_BASE) &&
		(offset < (`MADAM_REZ_BASE + 16'h0010)) && (offset[1:0] == 2'b00);
	assign sel_cmd = (offset == `MADAM_MATRIX_CMD);
	assign mat_sel = sel_mat || sel_vec || sel_rez || sel_cmd;

	assign busy = (state == madam_pkg::MAT_MAC);

	// every known command first moves the shadow results out.
	assign cmd_known = (cpu_din == `MATRIX_CMD_NOP) || (cpu_din == `MATRIX_CMD_4X4) ||
		(cpu_din == `MATRIX_CMD_3X3);

	// one signed 32x32 product per cycle.
	assign product = madam_pkg::mac_acc_t'(mat_q[{row, col}]) *
		madam_pkg::mac_acc_t'(vec_q[col]);
	assign mac_sum = acc + product;
	assign row_shift = mac_sum >>> `MATRIX_FRAC_BITS;	// back to 16.16.

	always_ff @(posedge clk_25m) begin
		if (!reset_n) begin
			state <= madam_pkg::MAT_IDLE;
			row <= 2'd0;
			col <= 2'd0;
			mat_last <= 2'd0;
			acc <= '0;
			for (int i = 0; i < 16; i++)
				mat_q[i] <= '0;
			for (int i = 0; i < 4; i++) begin
				vec_q[i] <= '0;
				rez_q[i] <= '0;
				rezt_q[i] <= '0;
			end
		end else begin
			case (state)
				madam_pkg::MAT_IDLE: begin
					if (cpu_wr && sel_mat)
						mat_q[offset[5:2]] <= cpu_din;
					if (cpu_wr && sel_vec)
						vec_q[offset[3:2]] <= cpu_din;
					if (cpu_wr && sel_cmd && cmd_known)
						rez_q <= rezt_q;	// publish the previous results.
					if (cpu_wr && sel_cmd &&
						((cpu_din == `MATRIX_CMD_4X4) || (cpu_din == `MATRIX_CMD_3X3))) begin
						state <= madam_pkg::MAT_MAC;
						row <= 2'd0;
						col <= 2'd0;
						acc <= '0;
						mat_last <= (cpu_din == `MATRIX_CMD_4X4) ? 2'd3 : 2'd2;
					end
				end
				madam_pkg::MAT_MAC: begin
					if (col == mat_last) begin
						rezt_q[row] <= row_shift[31:0];	// truncate to 32 bits.
						acc <= '0;
						col <= 2'd0;
						if (row == mat_last)
							state <= madam_pkg::MAT_IDLE;	// rezt[3] kept on 3x3.
						else
							row <= row + 2'd1;
					end else begin
						acc <= mac_sum;
						col <= col + 2'd1;
					end
				end
				default: state <= madam_pkg::MAT_IDLE;
			endcase
		end
	end

	// read side, same cycle as the offset.
	always_comb begin
		mat_rdata = '0;
		if (sel_mat)
			mat_rdata = mat_q[offset[5:2]];
		else if (sel_vec)
			mat_rdata = vec_q[offset[3:2]];
		else if (sel_rez)
			mat_rdata = rez_q[offset[3:2]];
		else if (sel_cmd)
			mat_rdata = {31'd0, busy};	// polled by the cpu.
	end

endmodule

// ==== rtl/pcsc_capture.sv ====
// line start detect on pcsc, horizontal counter restart
// and serial capture of the seven per-line video flags.
`include "madam_macros.svh"

module pcsc_capture (
	input logic clk_25m,
	input logic reset_n,
	input logic pcsc,
	output madam_pkg::hcount_t hcount,
	output madam_pkg::video_flags_t video_flags
);

	logic pcsc_dly;	// previous pcsc sample.
	logic [2:0] pcsc_index;	// 0 when idle, 1..7 while capturing.
	logic line_start;

	// a rising edge only starts a line when no capture runs,
	// so the flag bits toggling pcsc cannot retrigger it.
	assign line_start = pcsc && !pcsc_dly && (pcsc_index == 3'd0);

	always_ff @(posedge clk_25m) begin
		if (!reset_n) begin
			pcsc_dly <= 1'b0;
			pcsc_index <= 3'd0;
			hcount <= '0;
			video_flags <= '0;
		end else begin
			pcsc_dly <= pcsc;

			if (line_start) begin
				hcount <= '0;	// first pixel of the line.
				pcsc_index <= 3'd1;	// first flag comes next cycle.
			end else begin
				hcount <= hcount + 12'd1;
			end

			// flag k lands in bit k-1, the bit at the edge itself is ignored.
			if (pcsc_index != 3'd0) begin
				video_flags[pcsc_index - 3'd1] <= pcsc;
				if (pcsc_index == `MADAM_PCSC_LAST_BIT)
					pcsc_index <= 3'd0;	// capture done.
				else
					pcsc_index <= pcsc_index + 3'd1;
			end
		end
	end

endmodule
